//--- src/filter_pkg.sv
package filter_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int N_CHAN    = 4;
    localparam int W_CHAN    = 2;
    localparam int W_ADD_SEL = W_CHAN + 1;
    localparam int W_DIN     = 18;
    localparam int W_MULT    = 8;
    localparam int W_SHIFT   = 5;
    // Product keeps full precision, shift only moves it
    localparam int W_SCALED  = W_DIN + W_MULT;
    localparam int W_SUM     = W_SCALED + 1;
    localparam int W_DOUT    = 24;
    // Accumulator wide enough for sum plus previous output
    localparam int W_ACC     = W_SUM + 1;
    localparam int W_WR_ADDR = 4;
    localparam int W_WR_DATA = 24;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic        [W_CHAN-1:0]        chan_t;
    // Top bit set selects no add channel
    typedef logic        [W_ADD_SEL-1:0]     add_sel_t;
    typedef logic signed [W_DIN-1:0]         din_t;
    typedef logic signed [W_MULT-1:0]        mult_t;
    typedef logic        [W_SHIFT-1:0]       shift_t;
    typedef logic signed [W_SCALED-1:0]      scaled_t;
    typedef logic signed [W_SUM-1:0]         sum_t;
    typedef logic signed [W_ACC-1:0]         acc_t;
    typedef logic signed [W_DOUT-1:0]        dout_t;
    // All channels' initial values, channel 0 in the low bits
    typedef logic        [N_CHAN*W_DOUT-1:0] dout_vec_t;
    typedef logic        [W_WR_ADDR-1:0]     wr_addr_t;
    typedef logic        [W_WR_DATA-1:0]     wr_data_t;

    // ----------------------------------------
    // Write bus addresses
    // ----------------------------------------
    localparam wr_addr_t ADDR_CLR      = 4'd0;
    localparam wr_addr_t ADDR_INJ      = 4'd1;
    localparam wr_addr_t ADDR_MIN      = 4'd2;
    localparam wr_addr_t ADDR_MAX      = 4'd3;
    localparam wr_addr_t ADDR_INIT     = 4'd4;
    localparam wr_addr_t ADDR_MULT     = 4'd5;
    localparam wr_addr_t ADDR_SHIFT    = 4'd6;
    localparam wr_addr_t ADDR_ADD_CHAN = 4'd7;

    // Settings after reset
    localparam mult_t    MULT_RST    = '0;
    localparam shift_t   SHIFT_RST   = '0;
    localparam add_sel_t ADD_SEL_RST = {1'b1, {W_CHAN{1'b0}}};
    localparam dout_t    MIN_RST     = {1'b1, {(W_DOUT-1){1'b0}}};
    localparam dout_t    MAX_RST     = {1'b0, {(W_DOUT-1){1'b1}}};
    localparam dout_t    INIT_RST    = '0;

endpackage

//--- src/scale_path.sv
`timescale 1ns/1ps

module scale_path import filter_pkg::*; (
    input  logic     sys_clk_in,
    input  logic     reset,
    input  logic     dv_in,
    input  chan_t    chan_in,
    input  din_t     data_in,
    input  logic     wr_en,
    input  wr_addr_t wr_addr,
    input  chan_t    wr_chan,
    input  wr_data_t wr_data,
    input  logic     clr_valid,
    input  chan_t    clr_chan,
    output logic     scaled_valid,
    output chan_t    scaled_chan,
    output sum_t     scaled_sum
);

    // Per-channel settings
    mult_t    mult_mem  [N_CHAN];
    shift_t   shift_mem [N_CHAN];
    add_sel_t add_mem   [N_CHAN];
    // Latest scaled sample of each channel
    scaled_t  scaled_mem[N_CHAN];

    // Stage 1
    logic     dv_p1;
    chan_t    chan_p1;
    din_t     din_p1;

    // Stage 2 datapath
    scaled_t  product;
    scaled_t  shifted;
    scaled_t  add_term;
    add_sel_t add_sel;
    logic     drop_in;
    logic     drop_p1;

    // ----------------------------------------
    // Settings registers
    // ----------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (reset) begin
            for (int i = 0; i < N_CHAN; i++) begin
                mult_mem[i]  <= MULT_RST;
                shift_mem[i] <= SHIFT_RST;
                add_mem[i]   <= ADD_SEL_RST;
            end
        end else if (wr_en) begin
            // Only own addresses, rest belong to channel_bounds
            case (wr_addr)
                ADDR_MULT:     mult_mem[wr_chan]  <= mult_t'(wr_data[W_MULT-1:0]);
                ADDR_SHIFT:    shift_mem[wr_chan] <= shift_t'(wr_data[W_SHIFT-1:0]);
                ADDR_ADD_CHAN: add_mem[wr_chan]   <= add_sel_t'(wr_data[W_ADD_SEL-1:0]);
                default: ;
            endcase
        end
    end

    // Clear kills matching items entering and leaving stage 1
    assign drop_in = clr_valid && (clr_chan == chan_in);
    assign drop_p1 = clr_valid && (clr_chan == chan_p1);

    // ----------------------------------------
    // Stage 1
    // ----------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (reset) begin
            dv_p1 <= 1'b0;
        end else begin
            dv_p1 <= dv_in && !drop_in;
        end
        chan_p1 <= chan_in;
        din_p1  <= data_in;
    end

    // ----------------------------------------
    // Stage 2
    // ----------------------------------------
    always_comb begin
        // Full-width signed product
        product  = din_p1 * mult_mem[chan_p1];
        shifted  = product >>> shift_mem[chan_p1];
        add_sel  = add_mem[chan_p1];
        // Stored value before this edge, zero if no add channel
        if (add_sel[W_ADD_SEL-1]) begin
            add_term = '0;
        end else begin
            add_term = scaled_mem[add_sel[W_CHAN-1:0]];
        end
    end

    always_ff @(posedge sys_clk_in) begin
        if (reset) begin
            scaled_valid <= 1'b0;
        end else begin
            scaled_valid <= dv_p1 && !drop_p1;
        end
        scaled_chan <= chan_p1;
        scaled_sum  <= sum_t'(shifted) + sum_t'(add_term);
    end

    // Scaled-sample memory, clear wins over a same-cycle write
    always_ff @(posedge sys_clk_in) begin
        if (reset) begin
            for (int i = 0; i < N_CHAN; i++) begin
                scaled_mem[i] <= '0;
            end
        end else begin
            if (dv_p1 && !drop_p1) begin
                scaled_mem[chan_p1] <= shifted;
            end
            if (clr_valid) begin
                scaled_mem[clr_chan] <= '0;
            end
        end
    end

endmodule

//--- src/channel_bounds.sv
`timescale 1ns/1ps

module channel_bounds import filter_pkg::*; (
    input  logic      sys_clk_in,
    input  logic      reset,
    input  logic      dv_in,
    input  logic      wr_en,
    input  wr_addr_t  wr_addr,
    input  chan_t     wr_chan,
    input  wr_data_t  wr_data,
    input  chan_t     out_chan,
    output logic      inj_valid,
    output chan_t     inj_chan,
    output logic      clr_valid,
    output chan_t     clr_chan,
    output dout_t     bound_min,
    output dout_t     bound_max,
    output dout_t     init_value,
    output dout_vec_t init_all
);

    // Per-channel bounds and start values
    dout_t min_mem [N_CHAN];
    dout_t max_mem [N_CHAN];
    dout_t init_mem[N_CHAN];

    // Pending operation requests, one bit per channel
    logic [N_CHAN-1:0] inj_req;
    logic [N_CHAN-1:0] clr_req;

    // Injection slot
    logic  inj_grant;
    chan_t inj_pick;
    logic  inj_p1;
    chan_t inj_chan_p1;

    // Lowest set bit wins
    function automatic chan_t lowest_set(input logic [N_CHAN-1:0] req);
        chan_t idx;
        idx = '0;
        for (int i = N_CHAN - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = chan_t'(i);
            end
        end
        return idx;
    endfunction

    // ----------------------------------------
    // Settings registers
    // ----------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (reset) begin
            for (int i = 0; i < N_CHAN; i++) begin
                min_mem[i]  <= MIN_RST;
                max_mem[i]  <= MAX_RST;
                init_mem[i] <= INIT_RST;
            end
        end else if (wr_en) begin
            case (wr_addr)
                ADDR_MIN:  min_mem[wr_chan]  <= dout_t'(wr_data[W_DOUT-1:0]);
                ADDR_MAX:  max_mem[wr_chan]  <= dout_t'(wr_data[W_DOUT-1:0]);
                ADDR_INIT: init_mem[wr_chan] <= dout_t'(wr_data[W_DOUT-1:0]);
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Request flags
    // ----------------------------------------
    // Idle input cycle frees a stage 1 slot
    assign inj_grant = !dv_in && (|inj_req);
    assign inj_pick  = lowest_set(inj_req);

    // Clear pulse straight from the flag, gone next cycle
    assign clr_valid = |clr_req;
    assign clr_chan  = lowest_set(clr_req);

    always_ff @(posedge sys_clk_in) begin
        if (reset) begin
            inj_req <= '0;
            clr_req <= '0;
        end else begin
            if (inj_grant) begin
                inj_req[inj_pick] <= 1'b0;
            end
            if (clr_valid) begin
                clr_req[clr_chan] <= 1'b0;
            end
            // New request on same channel overrides the retire
            if (wr_en && (wr_addr == ADDR_INJ)) begin
                inj_req[wr_chan] <= wr_data[0];
            end
            if (wr_en && (wr_addr == ADDR_CLR)) begin
                clr_req[wr_chan] <= wr_data[0];
            end
        end
    end

    // ----------------------------------------
    // Injection slot, two stages to line up
    // ----------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (reset) begin
            inj_p1    <= 1'b0;
            inj_valid <= 1'b0;
        end else begin
            inj_p1    <= inj_grant;
            inj_valid <= inj_p1;
        end
        inj_chan_p1 <= inj_pick;
        inj_chan    <= inj_chan_p1;
    end

    // Lookup for the channel at the combining stage
    assign bound_min  = min_mem[out_chan];
    assign bound_max  = max_mem[out_chan];
    assign init_value = init_mem[out_chan];

    always_comb begin
        for (int i = 0; i < N_CHAN; i++) begin
            init_all[i*W_DOUT +: W_DOUT] = init_mem[i];
        end
    end

endmodule

//--- src/accumulate_clamp.sv
`timescale 1ns/1ps

module accumulate_clamp import filter_pkg::*; (
    input  logic      sys_clk_in,
    input  logic      reset,
    input  logic      scaled_valid,
    input  chan_t     scaled_chan,
    input  sum_t      scaled_sum,
    input  logic      inj_valid,
    input  chan_t     inj_chan,
    input  logic      clr_valid,
    input  chan_t     clr_chan,
    input  dout_t     bound_min,
    input  dout_t     bound_max,
    input  dout_t     init_value,
    input  dout_vec_t init_all,
    output chan_t     out_chan,
    output logic      dv_out,
    output chan_t     chan_out,
    output dout_t     data_out
);

    // Previous output of each channel
    dout_t prev_mem[N_CHAN];

    logic  item_valid;
    logic  item_drop;
    chan_t item_chan;
    acc_t  acc_next;
    dout_t clamped;

    // ----------------------------------------
    // Combine
    // ----------------------------------------
    // Sample and injection never share a slot
    assign item_chan  = inj_valid ? inj_chan : scaled_chan;
    assign item_valid = scaled_valid || inj_valid;
    assign item_drop  = clr_valid && (clr_chan == item_chan);
    // Bounds lookup happens in channel_bounds
    assign out_chan   = item_chan;

    always_comb begin
        if (inj_valid) begin
            acc_next = acc_t'(init_value);
        end else begin
            acc_next = acc_t'(scaled_sum) + acc_t'(prev_mem[item_chan]);
        end
        // Clamp at full width, max checked first
        if (acc_next > acc_t'(bound_max)) begin
            clamped = bound_max;
        end else if (acc_next < acc_t'(bound_min)) begin
            clamped = bound_min;
        end else begin
            clamped = dout_t'(acc_next);
        end
    end

    // ----------------------------------------
    // History
    // ----------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (reset) begin
            for (int i = 0; i < N_CHAN; i++) begin
                prev_mem[i] <= init_all[i*W_DOUT +: W_DOUT];
            end
        end else begin
            // Written back on the same edge it is read
            if (item_valid && !item_drop) begin
                prev_mem[item_chan] <= clamped;
            end
            if (clr_valid) begin
                prev_mem[clr_chan] <= init_all[int'(clr_chan)*W_DOUT +: W_DOUT];
            end
        end
    end

    // Output register
    always_ff @(posedge sys_clk_in) begin
        if (reset) begin
            dv_out <= 1'b0;
        end else begin
            dv_out <= item_valid && !item_drop;
        end
        chan_out <= item_chan;
        data_out <= clamped;
    end

endmodule

//--- src/output_filter.sv
`timescale 1ns/1ps

module output_filter import filter_pkg::*; (
    input  logic     sys_clk_in,
    input  logic     reset,
    input  logic     dv_in,
    input  chan_t    chan_in,
    input  din_t     data_in,
    input  logic     wr_en,
    input  wr_addr_t wr_addr,
    input  chan_t    wr_chan,
    input  wr_data_t wr_data,
    output logic     dv_out,
    output chan_t    chan_out,
    output dout_t    data_out
);

    // Scale path to combine stage
    logic      scaled_valid;
    chan_t     scaled_chan;
    sum_t      scaled_sum;

    // Bounds and requests to combine stage
    logic      inj_valid;
    chan_t     inj_chan;
    logic      clr_valid;
    chan_t     clr_chan;
    dout_t     bound_min;
    dout_t     bound_max;
    dout_t     init_value;
    dout_vec_t init_all;

    // Combine stage channel back to bounds lookup
    chan_t     out_chan;

    // ----------------------------------------
    // Gain, shift and add channel
    // ----------------------------------------
    scale_path u_scale_path (
        .sys_clk_in   (sys_clk_in),
        .reset        (reset),
        .dv_in        (dv_in),
        .chan_in      (chan_in),
        .data_in      (data_in),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_chan      (wr_chan),
        .wr_data      (wr_data),
        .clr_valid    (clr_valid),
        .clr_chan     (clr_chan),
        .scaled_valid (scaled_valid),
        .scaled_chan  (scaled_chan),
        .scaled_sum   (scaled_sum)
    );

    // Bounds, start values, clear and inject
    channel_bounds u_channel_bounds (
        .sys_clk_in (sys_clk_in),
        .reset      (reset),
        .dv_in      (dv_in),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_chan    (wr_chan),
        .wr_data    (wr_data),
        .out_chan   (out_chan),
        .inj_valid  (inj_valid),
        .inj_chan   (inj_chan),
        .clr_valid  (clr_valid),
        .clr_chan   (clr_chan),
        .bound_min  (bound_min),
        .bound_max  (bound_max),
        .init_value (init_value),
        .init_all   (init_all)
    );

    // Accumulate, clamp and output register
    accumulate_clamp u_accumulate_clamp (
        .sys_clk_in   (sys_clk_in),
        .reset        (reset),
        .scaled_valid (scaled_valid),
        .scaled_chan  (scaled_chan),
        .scaled_sum   (scaled_sum),
        .inj_valid    (inj_valid),
        .inj_chan     (inj_chan),
        .clr_valid    (clr_valid),
        .clr_chan     (clr_chan),
        .bound_min    (bound_min),
        .bound_max    (bound_max),
        .init_value   (init_value),
        .init_all     (init_all),
        .out_chan     (out_chan),
        .dv_out       (dv_out),
        .chan_out     (chan_out),
        .data_out     (data_out)
    );

endmodule

//--- test/output_filter_properties.sv
`timescale 1ns/1ps

module output_filter_properties import filter_pkg::*; (
    input logic  sys_clk_in,
    input logic  reset,
    input logic  scaled_valid,
    input logic  inj_valid,
    input dout_t bound_min,
    input dout_t bound_max,
    input logic  dv_out,
    input dout_t data_out
);

    // Sticky, set by any failing assertion
    logic fail_seen = 1'b0;

    // Registered output stays inside the bounds of the cycle before
    bounds_hold: assert property (
        @(posedge sys_clk_in) disable iff (reset)
        ((scaled_valid || inj_valid) && (bound_min <= bound_max))
            |=> ((data_out >= $past(bound_min)) && (data_out <= $past(bound_max))))
    else begin
        fail_seen = 1'b1;
        $error("data_out outside channel bounds");
    end

    // Each reset cycle leaves dv_out low on the next one
    dv_low_after_reset: assert property (
        @(posedge sys_clk_in) reset |=> !dv_out)
    else begin
        fail_seen = 1'b1;
        $error("dv_out high during or right after reset");
    end

    // Injection only uses idle slots
    slot_exclusive: assert property (
        @(posedge sys_clk_in) disable iff (reset) !(scaled_valid && inj_valid))
    else begin
        fail_seen = 1'b1;
        $error("scaled_valid and inj_valid high together");
    end

endmodule

//--- test/tb_output_filter.sv
`timescale 1ns/1ps

module tb_output_filter import filter_pkg::*; ();

    localparam int          CLK_HALF    = 4;
    localparam int          RST_CYCLES  = 4;
    localparam int          DRAIN_LIMIT = 50;
    localparam int          LATENCY     = 3;
    localparam logic [31:0] SEED        = 32'h9cc7d1e8;

    logic     sys_clk_in;
    logic     reset;
    logic     dv_in;
    chan_t    chan_in;
    din_t     data_in;
    logic     wr_en;
    wr_addr_t wr_addr;
    chan_t    wr_chan;
    wr_data_t wr_data;
    logic     dv_out;
    chan_t    chan_out;
    dout_t    data_out;

    // Reference model state per channel
    longint prev_m  [N_CHAN];
    longint scaled_m[N_CHAN];
    longint mult_m  [N_CHAN];
    int     shift_m [N_CHAN];
    int     add_m   [N_CHAN];
    longint min_m   [N_CHAN];
    longint max_m   [N_CHAN];
    longint init_m  [N_CHAN];

    // Expected outputs in arrival order
    chan_t  exp_chan_q[$];
    dout_t  exp_data_q[$];
    int     exp_due_q [$];

    int     cyc;
    logic   rst_drive;
    chan_t  ch;
    chan_t  other;
    din_t   d;
    logic   inj_now;
    chan_t  inj_ch;
    int     idle_cyc;

    always #CLK_HALF sys_clk_in = ~sys_clk_in;

    output_filter uut (
        .sys_clk_in (sys_clk_in),
        .reset      (reset),
        .dv_in      (dv_in),
        .chan_in    (chan_in),
        .data_in    (data_in),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_chan    (wr_chan),
        .wr_data    (wr_data),
        .dv_out     (dv_out),
        .chan_out   (chan_out),
        .data_out   (data_out)
    );

    bind accumulate_clamp output_filter_properties u_props (
        .sys_clk_in   (sys_clk_in),
        .reset        (reset),
        .scaled_valid (scaled_valid),
        .inj_valid    (inj_valid),
        .bound_min    (bound_min),
        .bound_max    (bound_max),
        .dv_out       (dv_out),
        .data_out     (data_out)
    );

    // Bound checker raises this flag on a failed assertion
    always @(posedge uut.u_accumulate_clamp.u_props.fail_seen) begin
        $display("Some tests failed");
        $fatal(1, "assertion failure in bound checker");
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic stop_run(input string why);
        $display("%s at time %0t", why, $time);
        $display("Some tests failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_chan(input string name, input chan_t exp, input chan_t act);
        if (act !== exp) begin
            $display("error: time %0t: %s expected %0d, got %0d", $time, name, exp, act);
            $display("Some tests failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic check_data(input string name, input dout_t exp, input dout_t act);
        if (act !== exp) begin
            $display("error: time %0t: %s expected %0d, got %0d", $time, name, exp, act);
            $display("Some tests failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    // Sampled on the falling edge
    task automatic observe_outputs();
        if (dv_out === 1'b1) begin
            if (exp_chan_q.size() == 0) begin
                stop_run("dv_out high while no output was expected");
            end
            if (exp_due_q[0] != cyc) begin
                stop_run($sformatf("output came in cycle %0d, expected in cycle %0d",
                                   cyc, exp_due_q[0]));
            end
            check_chan("chan_out", exp_chan_q.pop_front(), chan_out);
            check_data("data_out", exp_data_q.pop_front(), data_out);
            void'(exp_due_q.pop_front());
        end else if (dv_out !== 1'b0) begin
            stop_run("dv_out is unknown");
        end else if (exp_due_q.size() > 0 && exp_due_q[0] <= cyc) begin
            stop_run($sformatf("output expected in cycle %0d did not come", exp_due_q[0]));
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic longint clamp_value(input longint v, input longint lo, input longint hi);
        // Upper bound has priority
        if (v > hi) begin
            return hi;
        end else if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    function automatic void push_expected(input chan_t c, input longint v, input int due);
        exp_chan_q.push_back(c);
        exp_data_q.push_back(dout_t'(v));
        exp_due_q.push_back(due);
    endfunction

    function automatic void restore_defaults();
        for (int i = 0; i < N_CHAN; i++) begin
            mult_m[i]   = 0;
            shift_m[i]  = 0;
            add_m[i]    = N_CHAN;
            min_m[i]    = -(longint'(1) <<< 23);
            max_m[i]    = (longint'(1) <<< 23) - 1;
            init_m[i]   = 0;
            prev_m[i]   = 0;
            scaled_m[i] = 0;
        end
    endfunction

    function automatic void predict_sample(input chan_t c, input din_t x, input int due);
        longint prod;
        longint scaled;
        longint add_term;
        longint res;
        prod   = longint'(x) * mult_m[c];
        scaled = prod >>> shift_m[c];
        // Add term sees the stored value before this sample
        if (add_m[c] >= N_CHAN) begin
            add_term = 0;
        end else begin
            add_term = scaled_m[add_m[c]];
        end
        scaled_m[c] = scaled;
        res = clamp_value(scaled + add_term + prev_m[c], min_m[c], max_m[c]);
        prev_m[c] = res;
        push_expected(c, res, due);
    endfunction

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    // Inputs change right after the rising edge
    task automatic clock_in(input logic dv, input chan_t c, input din_t x, input logic we,
                            input wr_addr_t wa, input chan_t wc, input wr_data_t wd);
        @(posedge sys_clk_in);
        cyc++;
        reset   <= rst_drive;
        dv_in   <= dv;
        chan_in <= c;
        data_in <= x;
        wr_en   <= we;
        wr_addr <= wa;
        wr_chan <= wc;
        wr_data <= wd;
        @(negedge sys_clk_in);
        observe_outputs();
    endtask

    task automatic idle();
        clock_in(1'b0, '0, '0, 1'b0, '0, '0, '0);
    endtask

    task automatic send_sample(input chan_t c, input din_t x);
        clock_in(1'b1, c, x, 1'b0, '0, '0, '0);
        predict_sample(c, x, cyc + LATENCY);
    endtask

    task automatic write_reg(input wr_addr_t wa, input chan_t wc, input wr_data_t wd);
        clock_in(1'b0, '0, '0, 1'b1, wa, wc, wd);
        case (wa)
            ADDR_MIN:      min_m[wc]   = longint'(dout_t'(wd));
            ADDR_MAX:      max_m[wc]   = longint'(dout_t'(wd));
            ADDR_INIT:     init_m[wc]  = longint'(dout_t'(wd));
            ADDR_MULT:     mult_m[wc]  = longint'(mult_t'(wd[W_MULT-1:0]));
            ADDR_SHIFT:    shift_m[wc] = int'(wd[W_SHIFT-1:0]);
            ADDR_ADD_CHAN: add_m[wc]   = int'(wd[W_ADD_SEL-1:0]);
            ADDR_CLR: begin
                // History restarts from the raw initial value
                prev_m[wc]   = init_m[wc];
                scaled_m[wc] = 0;
            end
            default: ;
        endcase
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_chan_q.size() > 0) begin
            if (n >= DRAIN_LIMIT) begin
                stop_run("timeout waiting for dv_out");
            end
            idle();
            n++;
        end
        // Catch stray outputs
        repeat (4) idle();
    endtask

    // Items not out by the first reset edge are lost
    task automatic apply_reset(input int cycles);
        rst_drive = 1'b1;
        idle();
        exp_chan_q.delete();
        exp_data_q.delete();
        exp_due_q.delete();
        repeat (cycles - 1) idle();
        rst_drive = 1'b0;
        restore_defaults();
    endtask

    task automatic random_samples(input int count);
        repeat (count) begin
            send_sample(chan_t'($urandom % N_CHAN), din_t'($urandom));
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(SEED));
        sys_clk_in = 1'b0;
        reset      = 1'b1;
        dv_in      = 1'b0;
        chan_in    = '0;
        data_in    = '0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_chan    = '0;
        wr_data    = '0;
        cyc        = 0;
        restore_defaults();
        // Reset is already high at time zero
        apply_reset(RST_CYCLES - 1);

        // Unity gain and plain accumulation
        for (int i = 0; i < N_CHAN; i++) begin
            write_reg(ADDR_MULT, chan_t'(i), wr_data_t'(1));
        end
        random_samples(30);
        repeat (5) send_sample(chan_t'(2), din_t'($urandom));
        drain();

        // Random gain, shift and bounds
        for (int i = 0; i < N_CHAN; i++) begin
            write_reg(ADDR_MULT, chan_t'(i), wr_data_t'($urandom));
            write_reg(ADDR_SHIFT, chan_t'(i), wr_data_t'($urandom % 20));
            write_reg(ADDR_MIN, chan_t'(i), wr_data_t'(-longint'($urandom % (1 << 22)) - 1));
            write_reg(ADDR_MAX, chan_t'(i), wr_data_t'(longint'($urandom % (1 << 22)) + 1));
        end
        random_samples(60);
        drain();

        // Cross-channel add with none on channel 0
        write_reg(ADDR_ADD_CHAN, chan_t'(0), wr_data_t'(3'b100));
        for (int i = 1; i < N_CHAN; i++) begin
            write_reg(ADDR_ADD_CHAN, chan_t'(i), wr_data_t'($urandom % 5));
        end
        random_samples(60);
        drain();

        // Injection requests arrive while samples stream
        for (int i = 0; i < N_CHAN; i++) begin
            write_reg(ADDR_INIT, chan_t'(i), wr_data_t'($urandom));
        end
        for (int i = 0; i < 12; i++) begin
            ch      = chan_t'($urandom % N_CHAN);
            d       = din_t'($urandom);
            inj_now = (i == 2) || (i == 4) || (i == 6);
            inj_ch  = (i == 2) ? chan_t'(3) : ((i == 4) ? chan_t'(1) : chan_t'(2));
            clock_in(1'b1, ch, d, inj_now, ADDR_INJ, inj_ch, wr_data_t'(1));
            predict_sample(ch, d, cyc + LATENCY);
        end
        // Granted one per idle cycle in channel order
        idle_cyc = cyc + 1;
        for (int i = 1; i < N_CHAN; i++) begin
            prev_m[i] = clamp_value(init_m[i], min_m[i], max_m[i]);
            push_expected(chan_t'(i), prev_m[i], idle_cyc + LATENCY + i - 1);
        end
        drain();
        random_samples(20);
        drain();

        // Clear while idle with the neighbour adding from the cleared channel
        ch    = chan_t'($urandom % N_CHAN);
        other = ch + 1'b1;
        write_reg(ADDR_ADD_CHAN, other, wr_data_t'(ch));
        write_reg(ADDR_CLR, ch, wr_data_t'(1));
        // Clear pulse must pass before new samples
        repeat (2) idle();
        send_sample(other, din_t'($urandom));
        send_sample(ch, din_t'($urandom));
        random_samples(20);
        drain();

        // Reset with samples in flight
        random_samples(10);
        apply_reset(RST_CYCLES);
        random_samples(6);
        drain();
        for (int i = 0; i < N_CHAN; i++) begin
            write_reg(ADDR_MULT, chan_t'(i), wr_data_t'($urandom));
        end
        random_samples(12);
        drain();

        $display("All tests passed");
        $finish;
    end

endmodule

//--- build.f
src/filter_pkg.sv
src/scale_path.sv
src/channel_bounds.sv
src/accumulate_clamp.sv
src/output_filter.sv
test/output_filter_properties.sv
test/tb_output_filter.sv

//--- Bender.yml
package:
  name: output_filter

sources:
  # Design sources in compile order
  - files:
      - src/filter_pkg.sv
      - src/scale_path.sv
      - src/channel_bounds.sv
      - src/accumulate_clamp.sv
      - src/output_filter.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/output_filter_properties.sv
      - test/tb_output_filter.sv
